// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = inq_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/inq_pkg.sv
package inq_pkg;

	//////////////////////////////////////////////////
	// Queue geometry
	//////////////////////////////////////////////////

	localparam int INQ_DEPTH     = 16;
	localparam int INQ_WORDS     = 5;
	localparam int INQ_ROW_BYTES = 20;

	// One packet per row, five bus words wide
	typedef logic [8*INQ_ROW_BYTES-1:0] row_t;
	typedef logic [INQ_ROW_BYTES-1:0]   row_ben_t;
	typedef logic [3:0]                 slot_t;
	typedef logic [4:0]                 count_t;

	// Host bus
	typedef logic [31:0] wb_data_t;
	typedef logic [2:0]  wb_adr_t;
	typedef logic [3:0]  wb_sel_t;

	//////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////

	// Word addresses 0 to 4 are the data words of the open entry
	localparam wb_adr_t ADR_COMMIT = 3'd5;
	localparam wb_adr_t ADR_STATUS = 3'd6;

endpackage

// File: inq/inq_ctrl.sv
`timescale 1ns/1ps

module inq_ctrl import inq_pkg::*; (
	input  logic   clk,
	input  logic   reset_l,
	input  logic   commit,
	input  logic   out_ready,
	output slot_t  wr_slot,
	output count_t count,
	output logic   rd_en,
	output slot_t  rd_adr,
	output logic   out_valid
);

	slot_t  head;
	slot_t  tail;
	count_t unread;
	logic   rd_pend;
	logic   pop;

	assign pop     = out_valid & out_ready;
	assign wr_slot = tail;
	assign rd_adr  = head;

	// Issue when a committed row waits and the output is free or leaving
	assign rd_en = (unread != '0) & ~rd_pend & (~out_valid | out_ready);

	//////////////////////////////////////////////////
	// Pointers and counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_l) begin
			head   <= '0;
			tail   <= '0;
			count  <= '0;
			unread <= '0;
		end else begin
			if (commit)
				tail <= tail + 1'b1;
			if (rd_en)
				head <= head + 1'b1;

			// Occupancy covers rows still at the output
			case ({commit, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			case ({commit, rd_en})
				2'b10:   unread <= unread + 1'b1;
				2'b01:   unread <= unread - 1'b1;
				default: unread <= unread;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Output valid stage
	//////////////////////////////////////////////////

	// rd_data lands one edge after the rf takes the read
	always_ff @(posedge clk) begin
		if (!reset_l) begin
			rd_pend   <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			rd_pend <= rd_en;
			if (rd_pend)
				out_valid <= 1'b1;
			else if (pop)
				out_valid <= 1'b0;
		end
	end

	// Full gating in the bus slave keeps the queue in range
	a_count_max: assert property (
		@(posedge clk) disable iff (!reset_l)
		count <= count_t'(INQ_DEPTH)
	) else $error("occupancy %0d above depth", count);

	a_pop_nonzero: assert property (
		@(posedge clk) disable iff (!reset_l)
		pop |-> (count != '0)
	) else $error("pop with empty queue");

endmodule

// File: inq/inq_rf16x160.sv
`timescale 1ns/1ps

module inq_rf16x160 import inq_pkg::*; (
	input  logic     clk,
	input  logic     reset_l,
	input  logic     wr_en,
	input  slot_t    wr_adr,
	input  row_ben_t wr_ben,
	input  row_t     wr_data,
	input  logic     rd_en,
	input  slot_t    rd_adr,
	output row_t     rd_data
);

	row_t     mem [INQ_DEPTH];

	logic     wr_en_d1;
	slot_t    wr_adr_d1;
	row_ben_t wr_ben_d1;
	row_t     wr_data_d1;

	logic     rd_en_d1;
	slot_t    rd_adr_d1;

	//////////////////////////////////////////////////
	// Input registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_l) begin
			wr_en_d1 <= 1'b0;
			rd_en_d1 <= 1'b0;
		end else begin
			wr_en_d1 <= wr_en;
			rd_en_d1 <= rd_en;
		end
	end

	always_ff @(posedge clk) begin
		wr_adr_d1  <= wr_adr;
		wr_ben_d1  <= wr_ben;
		wr_data_d1 <= wr_data;
		rd_adr_d1  <= rd_adr;
	end

	//////////////////////////////////////////////////
	// Array write, one enable per byte lane
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_en_d1) begin
			for (int b = 0; b < INQ_ROW_BYTES; b++) begin
				if (wr_ben_d1[b])
					mem[wr_adr_d1][8*b +: 8] <= wr_data_d1[8*b +: 8];
			end
		end
	end

	// Read output holds until the next read
	always_ff @(posedge clk) begin
		if (!reset_l)
			rd_data <= '0;
		else if (rd_en_d1)
			rd_data <= mem[rd_adr_d1];
	end

	// The controller only reads committed rows, and the bus only writes the open row
	a_no_rw_collision: assert property (
		@(posedge clk) disable iff (!reset_l)
		!(wr_en_d1 && rd_en_d1 && (wr_adr_d1 == rd_adr_d1))
	) else $error("rf read and write hit row %0d in the same cycle", rd_adr_d1);

endmodule

// File: inq/inq_wb_slave.sv
`timescale 1ns/1ps

module inq_wb_slave import inq_pkg::*; (
	input  logic     clk,
	input  logic     reset_l,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_adr_t  wb_adr,
	input  wb_sel_t  wb_sel,
	input  wb_data_t wb_dat_w,
	input  slot_t    wr_slot,
	input  count_t   count,
	output wb_data_t wb_dat_r,
	output logic     wb_ack,
	output logic     wr_en,
	output slot_t    wr_adr,
	output row_ben_t wr_ben,
	output row_t     wr_data,
	output logic     commit
);

	logic     req;
	logic     is_data;
	logic     is_commit;
	logic     is_status;
	logic     full;
	logic     empty;
	logic     overflow;
	row_ben_t sel_ben;
	wb_data_t status;

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	// A request already acked is not taken again
	assign req       = wb_cyc & wb_stb & ~wb_ack;
	assign is_data   = (wb_adr < wb_adr_t'(INQ_WORDS));
	assign is_commit = (wb_adr == ADR_COMMIT);
	assign is_status = (wb_adr == ADR_STATUS);

	assign full  = (count == count_t'(INQ_DEPTH));
	assign empty = (count == '0);

	// Bus select lands on byte lanes 4w to 4w+3 of the row
	always_comb begin
		sel_ben = '0;
		if (is_data)
			sel_ben = row_ben_t'(wb_sel) << {wb_adr, 2'b00};
	end

	assign status = {24'd0, overflow, empty, full, count};

	//////////////////////////////////////////////////
	// Registered responses
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_l) begin
			wb_ack   <= 1'b0;
			wr_en    <= 1'b0;
			commit   <= 1'b0;
			overflow <= 1'b0;
		end else begin
			wb_ack <= req;
			wr_en  <= req & wb_we & is_data & ~full;
			commit <= req & wb_we & is_commit & ~full;
			if (req & wb_we & is_status)
				overflow <= 1'b0;
			else if (req & wb_we & (is_data | is_commit) & full)
				overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		wr_adr   <= wr_slot;
		wr_ben   <= sel_ben;
		wr_data  <= {INQ_WORDS{wb_dat_w}};
		wb_dat_r <= (req & ~wb_we & is_status) ? status : '0;
	end

	// Every transfer is at least two cycles long
	a_ack_single: assert property (
		@(posedge clk) disable iff (!reset_l)
		wb_ack |=> !wb_ack
	) else $error("wb_ack held high for two cycles");

endmodule

// File: logic/inq_top.sv
`timescale 1ns/1ps

module inq_top import inq_pkg::*; (
	input  logic     clk,
	input  logic     reset_l,
	input  logic     wb_cyc,
	input  logic     wb_stb,
	input  logic     wb_we,
	input  wb_adr_t  wb_adr,
	input  wb_sel_t  wb_sel,
	input  wb_data_t wb_dat_w,
	output wb_data_t wb_dat_r,
	output logic     wb_ack,
	input  logic     out_ready,
	output logic     out_valid,
	output row_t     out_data
);

	logic     wr_en;
	slot_t    wr_adr;
	row_ben_t wr_ben;
	row_t     wr_data;
	logic     commit;
	slot_t    wr_slot;
	count_t   count;
	logic     rd_en;
	slot_t    rd_adr;

	//////////////////////////////////////////////////
	// Bus stage
	//////////////////////////////////////////////////

	inq_wb_slave wb0 (
		.clk      (clk),
		.reset_l  (reset_l),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_sel   (wb_sel),
		.wb_dat_w (wb_dat_w),
		.wr_slot  (wr_slot),
		.count    (count),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.wr_en    (wr_en),
		.wr_adr   (wr_adr),
		.wr_ben   (wr_ben),
		.wr_data  (wr_data),
		.commit   (commit)
	);

	// Array and pop stages
	inq_rf16x160 rf0 (
		.clk     (clk),
		.reset_l (reset_l),
		.wr_en   (wr_en),
		.wr_adr  (wr_adr),
		.wr_ben  (wr_ben),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_adr  (rd_adr),
		.rd_data (out_data)
	);

	inq_ctrl ctrl0 (
		.clk       (clk),
		.reset_l   (reset_l),
		.commit    (commit),
		.out_ready (out_ready),
		.wr_slot   (wr_slot),
		.count     (count),
		.rd_en     (rd_en),
		.rd_adr    (rd_adr),
		.out_valid (out_valid)
	);

endmodule

// File: sim.f
common/inq_pkg.sv
inq/inq_rf16x160.sv
inq/inq_wb_slave.sv
inq/inq_ctrl.sv
logic/inq_top.sv
tb/tb_clkgen.sv
tb/inq_tb.sv

// File: tb/inq_tb.sv
`timescale 1ns/1ps

module inq_tb import inq_pkg::*; ();

	localparam int N_TESTS       = 6;
	localparam int MODE_SINGLE   = 0;
	localparam int MODE_FILL     = 1;
	localparam int MODE_RANDOM   = 2;
	localparam int MODE_STATUS   = 3;
	localparam int DRIVE_DLY     = 2;
	localparam int ACK_TIMEOUT   = 16;
	localparam int DRAIN_TIMEOUT = 64;

	logic     clk;
	logic     reset_l;
	logic     wb_cyc;
	logic     wb_stb;
	logic     wb_we;
	wb_adr_t  wb_adr;
	wb_sel_t  wb_sel;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic     wb_ack;
	logic     out_ready;
	logic     out_valid;
	row_t     out_data;

	// Test table, one row per test
	string    t_name    [N_TESTS];
	row_t     t_data    [N_TESTS];
	row_ben_t t_sel     [N_TESTS];
	int       t_ow_word [N_TESTS];
	wb_data_t t_ow_data [N_TESTS];
	wb_sel_t  t_ow_sel  [N_TESTS];
	int       t_mode    [N_TESTS];
	int       t_npkt    [N_TESTS];

	// Reference model of the queue
	row_t  exp_q [$];
	int    exp_count;
	bit    exp_ovf;
	int    errors;
	bit    timed_out;
	string cur_name;

	tb_clkgen clkgen0 (
		.clk     (clk),
		.reset_l (reset_l)
	);

	inq_top dut0 (
		.clk       (clk),
		.reset_l   (reset_l),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_sel    (wb_sel),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	//////////////////////////////////////////////////
	// Table and expected values
	//////////////////////////////////////////////////

	task automatic set_row(input int i, input string name, input row_t data,
			input row_ben_t sel, input int ow_word, input wb_data_t ow_data,
			input wb_sel_t ow_sel, input int mode, input int npkt);
		t_name[i]    = name;
		t_data[i]    = data;
		t_sel[i]     = sel;
		t_ow_word[i] = ow_word;
		t_ow_data[i] = ow_data;
		t_ow_sel[i]  = ow_sel;
		t_mode[i]    = mode;
		t_npkt[i]    = npkt;
	endtask

	// Packet k of a row differs from packet 0 by a per-packet salt
	function automatic row_t packet_words(input int i, input int k);
		wb_data_t salt;
		salt = wb_data_t'(k) * 32'h01030507;
		return t_data[i] ^ {INQ_WORDS{salt}};
	endfunction

	function automatic wb_data_t merge_bytes(input wb_data_t old_w, input wb_data_t new_w,
			input wb_sel_t sel);
		wb_data_t res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	function automatic row_t expected_row(input int i, input int k);
		row_t src;
		row_t res;
		src = packet_words(i, k);
		res = '0;
		for (int w = 0; w < INQ_WORDS; w++) begin
			res[32*w +: 32] = merge_bytes(res[32*w +: 32], src[32*w +: 32], t_sel[i][4*w +: 4]);
			if (t_ow_word[i] == w)
				res[32*w +: 32] = merge_bytes(res[32*w +: 32], t_ow_data[i], t_ow_sel[i]);
		end
		return res;
	endfunction

	// Count in 4:0, then full, empty and the sticky overflow
	function automatic wb_data_t status_word(input int cnt, input bit ovf);
		return {24'd0, ovf, cnt == 0, cnt == INQ_DEPTH, 5'(cnt)};
	endfunction

	task automatic check_word(input string what, input wb_data_t exp_w, input wb_data_t act_w);
		assert (act_w === exp_w) else begin
			$display("ERR %s %s: expected %h, actual %h", cur_name, what, exp_w, act_w);
			errors++;
		end
	endtask

	task automatic check_row(input string what, input row_t exp_r, input row_t act_r);
		assert (act_r === exp_r) else begin
			$display("ERR %s %s: expected %h, actual %h", cur_name, what, exp_r, act_r);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// Wishbone driver
	//////////////////////////////////////////////////

	task automatic bus_xfer(input logic we, input wb_adr_t adr, input wb_sel_t sel,
			input wb_data_t dat, output wb_data_t rdata);
		int n;
		n = 0;
		@(posedge clk);
		#DRIVE_DLY;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_sel   = sel;
		wb_dat_w = dat;
		do begin
			@(posedge clk);
			#DRIVE_DLY;
			n++;
		end while (!wb_ack && n < ACK_TIMEOUT);
		if (!wb_ack) begin
			$display("%s: no wb_ack within %0d cycles at word address %0d", cur_name,
				ACK_TIMEOUT, adr);
			errors++;
			timed_out = 1'b1;
		end
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_write(input wb_adr_t adr, input wb_sel_t sel, input wb_data_t dat);
		wb_data_t unused;
		bus_xfer(1'b1, adr, sel, dat, unused);
	endtask

	task automatic read_check(input string what, input wb_adr_t adr, input wb_data_t exp_w);
		wb_data_t rd;
		bus_xfer(1'b0, adr, 4'hf, '0, rd);
		check_word(what, exp_w, rd);
	endtask

	task automatic push_packet(input int i, input int k);
		row_t src;
		src = packet_words(i, k);
		for (int w = 0; w < INQ_WORDS; w++)
			bus_write(wb_adr_t'(w), t_sel[i][4*w +: 4], src[32*w +: 32]);
		if (t_ow_word[i] >= 0)
			bus_write(wb_adr_t'(t_ow_word[i]), t_ow_sel[i], t_ow_data[i]);
		bus_write(ADR_COMMIT, 4'hf, '0);
		exp_count++;
		exp_q.push_back(expected_row(i, k));
	endtask

	//////////////////////////////////////////////////
	// Consumer model
	//////////////////////////////////////////////////

	task automatic drain_packets(input int n, input bit rnd);
		int   got;
		int   idle;
		bit   held;
		row_t held_data;
		got  = 0;
		idle = 0;
		held = 1'b0;
		held_data = '0;
		while (got < n && idle < DRAIN_TIMEOUT) begin
			@(posedge clk);
			#DRIVE_DLY;
			if (held)
				check_row("held out_data", held_data, out_data);
			out_ready = rnd ? (($urandom() % 2) == 1) : 1'b1;
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("%s: packet popped with none expected", cur_name);
					errors++;
				end else begin
					check_row($sformatf("packet %0d", got), exp_q.pop_front(), out_data);
				end
				exp_count--;
				got++;
				idle = 0;
			end else begin
				idle++;
			end
			held      = out_valid && !out_ready;
			held_data = out_data;
		end
		// Last pop takes effect on this edge
		@(posedge clk);
		#DRIVE_DLY;
		out_ready = 1'b0;
		if (got < n) begin
			$display("%s: out_valid stayed low after %0d of %0d packets", cur_name, got, n);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////
	// Test flows
	//////////////////////////////////////////////////

	task automatic run_single(input int i);
		read_check("status before commit", ADR_STATUS, status_word(exp_count, exp_ovf));
		push_packet(i, 0);
		read_check("status after commit", ADR_STATUS, status_word(exp_count, exp_ovf));
		drain_packets(1, 1'b0);
		read_check("status after drain", ADR_STATUS, status_word(exp_count, exp_ovf));
	endtask

	task automatic run_fill(input int i);
		for (int k = 0; k < t_npkt[i]; k++)
			push_packet(i, k);
		read_check("status when full", ADR_STATUS, status_word(exp_count, exp_ovf));
		// One commit too many
		bus_write(ADR_COMMIT, 4'hf, '0);
		exp_ovf = 1'b1;
		read_check("status after extra commit", ADR_STATUS, status_word(exp_count, exp_ovf));
		drain_packets(t_npkt[i], 1'b0);
	endtask

	task automatic run_random(input int i);
		for (int k = 0; k < t_npkt[i]; k++)
			push_packet(i, k);
		drain_packets(t_npkt[i], 1'b1);
		read_check("status after drain", ADR_STATUS, status_word(exp_count, exp_ovf));
	endtask

	task automatic run_status(input int i);
		read_check("status before clear", ADR_STATUS, status_word(exp_count, exp_ovf));
		bus_write(ADR_STATUS, 4'hf, '0);
		exp_ovf = 1'b0;
		read_check("status after clear", ADR_STATUS, status_word(exp_count, exp_ovf));
		for (int a = 0; a < 8; a++) begin
			if (a != int'(ADR_STATUS))
				read_check($sformatf("read of address %0d", a), wb_adr_t'(a), '0);
		end
	endtask

	initial begin
		int err_before;
		int n_pass;
		int n_fail;
		int n;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_sel    = '0;
		wb_dat_w  = '0;
		out_ready = 1'b0;
		errors    = 0;
		timed_out = 1'b0;
		exp_count = 0;
		exp_ovf   = 1'b0;
		n_pass    = 0;
		n_fail    = 0;
		cur_name  = "reset";
		void'($urandom(32'h3361af5c));

		set_row(0, "round_trip", {32'h5a5a0f0f, 32'hc3c3a5a5, 32'h76543210, 32'hfedcba98,
			32'h01234567}, 20'hfffff, -1, '0, '0, MODE_SINGLE, 1);
		set_row(1, "byte_merge", {32'h11112222, 32'h33334444, 32'h55556666, 32'h77778888,
			32'h9999aaaa}, 20'hfffff, 2, 32'hcafef00d, 4'b0101, MODE_SINGLE, 1);
		set_row(2, "byte_merge_hi", {32'hdeadbeef, 32'h0badf00d, 32'h8badcafe, 32'h12345678,
			32'h87654321}, 20'hfffff, 4, 32'h9e3779b9, 4'b1000, MODE_SINGLE, 1);
		set_row(3, "fill_overflow", {32'ha0a1a2a3, 32'hb0b1b2b3, 32'hc0c1c2c3, 32'hd0d1d2d3,
			32'he0e1e2e3}, 20'hfffff, -1, '0, '0, MODE_FILL, INQ_DEPTH);
		set_row(4, "backpressure", {32'h13579bdf, 32'h2468ace0, 32'hf0e1d2c3, 32'hb4a59687,
			32'h78695a4b}, 20'hfffff, -1, '0, '0, MODE_RANDOM, 10);
		set_row(5, "status_housekeeping", '0, '0, -1, '0, '0, MODE_STATUS, 0);

		n = 0;
		while (reset_l !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (reset_l !== 1'b1) begin
			$display("reset_l never released");
			errors++;
			timed_out = 1'b1;
		end

		for (int i = 0; i < N_TESTS && !timed_out; i++) begin
			cur_name   = t_name[i];
			err_before = errors;
			case (t_mode[i])
				MODE_SINGLE: run_single(i);
				MODE_FILL:   run_fill(i);
				MODE_RANDOM: run_random(i);
				default:     run_status(i);
			endcase
			if (errors == err_before) begin
				$display("test %s: ok", cur_name);
				n_pass++;
			end else begin
				$display("test %s: %0d error(s)", cur_name, errors - err_before);
				n_fail++;
			end
		end

		$display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk,
	output logic reset_l
);

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 4;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Release just after an edge, like the rest of the stimulus
	initial begin
		reset_l = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 reset_l = 1'b1;
	end

endmodule
